// File: common/repack_macros.svh
`ifndef REPACK_MACROS_SVH
`define REPACK_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Repack geometry
//////////////////////////////////////////////////////////////////////

// Bits in one pixel unit
`define REPACK_UNIT_BITS 8

// Units in one FIFO word
// Power of two, so position counters wrap on their own
`define REPACK_MAX_UNITS 4

// Word FIFO depth
`define REPACK_FIFO_DEPTH 16

// Read-side enable to output latency in cycles
`define REPACK_OUT_DLY 3

`endif

// File: common/repack_pkg.sv
`include "repack_macros.svh"

package repack_pkg;

    // One pixel unit
    typedef logic [`REPACK_UNIT_BITS-1:0] unit_t;

    // One packed word
    // Unit 0 sits in the low bits
    typedef unit_t [`REPACK_MAX_UNITS-1:0] word_t;

    // Unit position inside a word
    typedef logic [$clog2(`REPACK_MAX_UNITS)-1:0] pos_t;

    // Units per pixel, 0 up to a full word
    // One bit wider than pos_t so a full word fits
    // Zero parks both stations
    typedef logic [$clog2(`REPACK_MAX_UNITS):0] units_t;

endpackage

// File: pixel_pack/pixel_pack.sv
`timescale 1ns/1ps
`include "repack_macros.svh"

module pixel_pack (
    input  logic               CLK_I,
    input  logic               RST_I,
    input  logic               vs,
    input  logic               de,
    input  repack_pkg::units_t units,
    input  repack_pkg::word_t  data,
    output logic               wr_en,
    output repack_pkg::word_t  wr_data
);

    localparam int WORD_BITS = `REPACK_MAX_UNITS * `REPACK_UNIT_BITS;
    localparam int POS_BITS  = $bits(repack_pkg::pos_t);

    // Frame sync edge
    logic                   vs_d;
    logic                   vs_rise;

    // Units per pixel for the running frame
    repack_pkg::units_t     units_q;
    repack_pkg::units_t     units_eff;

    // Fill position and active accumulator half
    repack_pkg::pos_t       pos;
    repack_pkg::pos_t       pos_eff;
    logic                   half;
    logic                   half_eff;
    logic [POS_BITS:0]      pos_sum;
    logic                   wrap;

    // Pixel lanes and the two-word accumulator
    logic [WORD_BITS-1:0]   lane_mask;
    logic [2*WORD_BITS-1:0] pix_shift;
    logic [2*WORD_BITS-1:0] mask_shift;
    logic [2*WORD_BITS-1:0] pix_lane;
    logic [2*WORD_BITS-1:0] mask_lane;
    logic [2*WORD_BITS-1:0] acc;
    logic [2*WORD_BITS-1:0] acc_next;

    //////////////////////////////////////////////////////////////////////
    // Frame start
    //////////////////////////////////////////////////////////////////////

    assign vs_rise = vs & ~vs_d;

    // New unit count and a clean start position on the sync rise
    // Lets a pixel on the rise cycle itself land at bit 0
    assign units_eff = vs_rise ? units : units_q;
    assign pos_eff   = vs_rise ? '0 : pos;
    assign half_eff  = vs_rise ? 1'b0 : half;

    //////////////////////////////////////////////////////////////////////
    // Position and lane placement
    //////////////////////////////////////////////////////////////////////

    // Carry out of the position sum marks a completed word
    assign pos_sum = {1'b0, pos_eff} + units_eff;
    assign wrap    = de & pos_sum[POS_BITS];

    // Keep only the low units of the input pixel
    assign lane_mask = {WORD_BITS{1'b1}} >>
                       ((`REPACK_MAX_UNITS - units_eff) * `REPACK_UNIT_BITS);

    // Move pixel to the fill position, may spill into the upper word
    assign pix_shift  = {{WORD_BITS{1'b0}}, data & lane_mask} <<
                        (pos_eff * `REPACK_UNIT_BITS);
    assign mask_shift = {{WORD_BITS{1'b0}}, lane_mask} <<
                        (pos_eff * `REPACK_UNIT_BITS);

    // Upper half active means the two halves trade places
    assign pix_lane  = half_eff ? {pix_shift[WORD_BITS-1:0], pix_shift[2*WORD_BITS-1:WORD_BITS]}
                                : pix_shift;
    assign mask_lane = half_eff ? {mask_shift[WORD_BITS-1:0], mask_shift[2*WORD_BITS-1:WORD_BITS]}
                                : mask_shift;

    // Merge only the pixel's own units
    assign acc_next = de ? ((acc & ~mask_lane) | pix_lane) : acc;

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            vs_d    <= 1'b0;
            units_q <= '0;
            pos     <= '0;
            half    <= 1'b0;
            wr_en   <= 1'b0;
        end else begin
            vs_d    <= vs;
            units_q <= units_eff;
            pos     <= de ? pos_sum[POS_BITS-1:0] : pos_eff;
            // Flip halves once the active one is full
            half    <= half_eff ^ wrap;
            wr_en   <= wrap;
        end
    end

    // Completed half goes out on the cycle after the last unit arrives
    always_ff @(posedge CLK_I) begin
        acc <= acc_next;
        if (wrap) begin
            wr_data <= half_eff ? acc_next[2*WORD_BITS-1:WORD_BITS]
                                : acc_next[WORD_BITS-1:0];
        end
    end

endmodule

// File: word_fifo/word_fifo.sv
`timescale 1ns/1ps
`include "repack_macros.svh"

module word_fifo #(
    parameter type payload_t = repack_pkg::word_t,
    parameter int  DEPTH     = `REPACK_FIFO_DEPTH
) (
    input  logic     CLK_I,
    input  logic     RST_I,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty,
    output logic     full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [PTR_BITS:0]   count_t;

    // Storage ring
    payload_t mem [DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    count_t   count;

    // Accepted accesses
    logic     wr_ok;
    logic     rd_ok;

    // Pointer step with wrap at any depth
    function automatic ptr_t ptr_inc(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == count_t'(DEPTH));

    // Write when full or read when empty is dropped
    assign wr_ok = wr_en & ~full;
    assign rd_ok = rd_en & ~empty;

    //////////////////////////////////////////////////////////////////////
    // Pointers and fill level
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // RAM-style port, data one cycle after the read and held until the next
    always_ff @(posedge CLK_I) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

// File: pixel_unpack/pixel_unpack.sv
`timescale 1ns/1ps
`include "repack_macros.svh"

module pixel_unpack (
    input  logic               CLK_I,
    input  logic               RST_I,
    input  logic               vs_req,
    input  logic               hs_req,
    input  logic               de_req,
    input  repack_pkg::units_t units,
    output logic               rd_en,
    input  repack_pkg::word_t  rd_data,
    output logic               out_vs,
    output logic               out_hs,
    output logic               out_de,
    output repack_pkg::word_t  out_data
);

    localparam int WORD_BITS = `REPACK_MAX_UNITS * `REPACK_UNIT_BITS;
    localparam int POS_BITS  = $bits(repack_pkg::pos_t);
    localparam int DLY       = `REPACK_OUT_DLY;

    // Sync delay chains
    // Tap 0 lags the request by one cycle
    logic [DLY-1:0]         vs_pipe;
    logic [DLY-1:0]         hs_pipe;
    logic [DLY-1:0]         de_pipe;
    logic                   de_d1;
    logic                   de_d2;
    logic                   vs_rise;
    logic                   de_rise;

    // Units per pixel for the running frame
    repack_pkg::units_t     units_q;
    repack_pkg::units_t     units_eff;

    // Read issue
    logic                   pref_armed;
    logic                   prefetch;
    logic                   look_rd;

    // Run counter on the request side
    repack_pkg::pos_t       run_pos;
    repack_pkg::pos_t       run_eff;
    logic [POS_BITS:0]      run_sum;
    logic [POS_BITS:0]      look_sum;

    // Word return into the A/B pair
    logic                   rd_q;
    logic                   ab_sel;
    repack_pkg::word_t      a_q;
    repack_pkg::word_t      b_q;

    // Shift counter on the output side
    repack_pkg::pos_t       sft_pos;
    logic [POS_BITS:0]      sft_sum;
    logic                   order;
    logic [2*WORD_BITS-1:0] pair;
    logic [2*WORD_BITS-1:0] pair_shift;

    assign de_d1 = de_pipe[0];
    // Last tap ahead of the output register
    assign de_d2 = de_pipe[DLY-2];

    assign vs_rise = vs_req & ~vs_pipe[0];
    assign de_rise = de_req & ~de_d1;

    assign units_eff = vs_rise ? units : units_q;
    assign run_eff   = vs_rise ? '0 : run_pos;

    //////////////////////////////////////////////////////////////////////
    // Read requests
    //////////////////////////////////////////////////////////////////////

    // First word of a frame fetched on the first enable rise
    assign prefetch = de_rise & (pref_armed | vs_rise);

    // Next pixel from the current run position
    // Carry means it reaches the word end, so fetch the following word now
    assign look_sum = {1'b0, run_pos} + units_q;
    assign look_rd  = de_d1 & look_sum[POS_BITS];

    assign rd_en = prefetch | look_rd;

    assign run_sum = {1'b0, run_eff} + units_eff;

    //////////////////////////////////////////////////////////////////////
    // Output select
    //////////////////////////////////////////////////////////////////////

    // Even words sit in A, odd words in B
    // order tracks which one holds the current word
    assign sft_sum    = {1'b0, sft_pos} + units_q;
    assign pair       = order ? {a_q, b_q} : {b_q, a_q};
    assign pair_shift = pair >> (sft_pos * `REPACK_UNIT_BITS);

    assign out_vs = vs_pipe[DLY-1];
    assign out_hs = hs_pipe[DLY-1];
    assign out_de = de_pipe[DLY-1];

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            vs_pipe    <= '0;
            hs_pipe    <= '0;
            de_pipe    <= '0;
            units_q    <= '0;
            pref_armed <= 1'b0;
            run_pos    <= '0;
            rd_q       <= 1'b0;
            ab_sel     <= 1'b0;
            sft_pos    <= '0;
            order      <= 1'b0;
        end else begin
            vs_pipe <= {vs_pipe[DLY-2:0], vs_req};
            hs_pipe <= {hs_pipe[DLY-2:0], hs_req};
            de_pipe <= {de_pipe[DLY-2:0], de_req};
            units_q <= units_eff;
            // Once per frame
            if (prefetch) begin
                pref_armed <= 1'b0;
            end else if (vs_rise) begin
                pref_armed <= 1'b1;
            end
            run_pos <= de_req ? run_sum[POS_BITS-1:0] : run_eff;
            rd_q    <= rd_en;
            // Alternate A then B from the first read of a frame
            if (vs_rise) begin
                ab_sel <= 1'b0;
            end else if (rd_q) begin
                ab_sel <= ~ab_sel;
            end
            // Step past each delivered pixel
            if (vs_rise) begin
                sft_pos <= '0;
                order   <= 1'b0;
            end else if (de_d2) begin
                sft_pos <= sft_sum[POS_BITS-1:0];
                order   <= order ^ sft_sum[POS_BITS];
            end
        end
    end

    // FIFO data lands one cycle after the read strobe
    always_ff @(posedge CLK_I) begin
        if (rd_q & ~ab_sel) begin
            a_q <= rd_data;
        end
        if (rd_q & ab_sel) begin
            b_q <= rd_data;
        end
        if (de_d2) begin
            out_data <= pair_shift[WORD_BITS-1:0];
        end
    end

endmodule

// File: design/repack_top.sv
`timescale 1ns/1ps
`include "repack_macros.svh"

module repack_top (
    input  logic               CLK_I,
    input  logic               RST_I,
    // Write side video
    input  logic               in_vs,
    input  logic               in_hs,
    input  logic               in_de,
    input  repack_pkg::word_t  in_data,
    input  repack_pkg::units_t in_units,
    // Read side pixel requests
    input  logic               out_vs_req,
    input  logic               out_hs_req,
    input  logic               out_de_req,
    input  repack_pkg::units_t out_units,
    // Rebuilt video
    output logic               out_vs,
    output logic               out_hs,
    output logic               out_de,
    output repack_pkg::word_t  out_data,
    // FIFO status
    output logic               fifo_empty,
    output logic               fifo_full
);

    // Packed word stream
    logic              wr_en;
    repack_pkg::word_t wr_data;
    logic              rd_en;
    repack_pkg::word_t rd_data;

    // Write station
    // Line sync plays no part in packing
    pixel_pack pack_i (
        .CLK_I   (CLK_I),
        .RST_I   (RST_I),
        .vs      (in_vs),
        .de      (in_de),
        .units   (in_units),
        .data    (in_data),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    word_fifo #(
        .payload_t (repack_pkg::word_t),
        .DEPTH     (`REPACK_FIFO_DEPTH)
    ) fifo_i (
        .CLK_I   (CLK_I),
        .RST_I   (RST_I),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    // Read station
    pixel_unpack unpack_i (
        .CLK_I    (CLK_I),
        .RST_I    (RST_I),
        .vs_req   (out_vs_req),
        .hs_req   (out_hs_req),
        .de_req   (out_de_req),
        .units    (out_units),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .out_vs   (out_vs),
        .out_hs   (out_hs),
        .out_de   (out_de),
        .out_data (out_data)
    );

endmodule

// File: sim/repack_tb.sv
`timescale 1ns/1ps
`include "repack_macros.svh"

module repack_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DLY    = 1;
    localparam int DLY          = `REPACK_OUT_DLY;
    localparam int MAX_UNITS    = `REPACK_MAX_UNITS;
    localparam int FIFO_DEPTH   = `REPACK_FIFO_DEPTH;
    localparam int LINE_GAP     = 3;
    localparam int SYNC_CYCLES  = 2;
    localparam int WR_IDLE      = 4;
    localparam int IDLE_CHECKS  = 3;
    localparam int NUM_ROWS     = 6;
    localparam int FRAME_CYCLES = 200;
    localparam int WATCHDOG_NS  = (NUM_ROWS * FRAME_CYCLES + RESET_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h61309004;

    //////////////////////////////////////////////////////////////////////
    // Frame table
    //////////////////////////////////////////////////////////////////////

    // Units per pixel, pixels, line length, gap flag, words expected in the FIFO
    localparam int ROW_UNITS    [NUM_ROWS] = '{4, 1, 2, 3, 3, 4};
    localparam int ROW_PIXELS   [NUM_ROWS] = '{16, 16, 16, 16, 16, 16};
    localparam int ROW_LINE_LEN [NUM_ROWS] = '{8, 8, 8, 8, 8, 8};
    localparam int ROW_GAPS     [NUM_ROWS] = '{0, 0, 0, 0, 1, 0};
    localparam int ROW_WORDS    [NUM_ROWS] = '{16, 4, 8, 12, 12, 16};

    logic               CLK_I;
    logic               RST_I;
    logic               in_vs;
    logic               in_hs;
    logic               in_de;
    repack_pkg::word_t  in_data;
    repack_pkg::units_t in_units;
    logic               out_vs_req;
    logic               out_hs_req;
    logic               out_de_req;
    repack_pkg::units_t out_units;
    logic               out_vs;
    logic               out_hs;
    logic               out_de;
    repack_pkg::word_t  out_data;
    logic               fifo_empty;
    logic               fifo_full;

    // Scoreboard of written pixels in FIFO order
    repack_pkg::word_t  exp_pix_q [$];
    int                 exp_units_q [$];
    repack_pkg::word_t  mon_exp;
    repack_pkg::word_t  mon_got;
    int                 mon_units;
    int                 rx_count    = 0;
    int                 total_words = 0;
    int                 fail_count  = 0;

    // Request syncs seen on earlier cycles
    // Entry 0 is the newest
    logic [DLY-1:0]     vs_hist = '0;
    logic [DLY-1:0]     hs_hist = '0;
    logic [DLY-1:0]     de_hist = '0;

    repack_top dut_i (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .in_vs      (in_vs),
        .in_hs      (in_hs),
        .in_de      (in_de),
        .in_data    (in_data),
        .in_units   (in_units),
        .out_vs_req (out_vs_req),
        .out_hs_req (out_hs_req),
        .out_de_req (out_de_req),
        .out_units  (out_units),
        .out_vs     (out_vs),
        .out_hs     (out_hs),
        .out_de     (out_de),
        .out_data   (out_data),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full)
    );

    always #(CLK_PERIOD / 2) CLK_I = ~CLK_I;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string line);
        fail_count++;
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge CLK_I);
        #(DRIVE_DLY);
    endtask

    // Ones over the low units of a pixel
    function automatic repack_pkg::word_t low_unit_mask(input int units);
        repack_pkg::word_t m;
        m = '0;
        for (int i = 0; i < MAX_UNITS; i++) begin
            if (i < units) begin
                m[i] = '1;
            end
        end
        return m;
    endfunction

    // Next legal count in the cycle 4 -> 1 -> 2 -> 3 -> 4
    function automatic int other_units(input int u);
        return (u % MAX_UNITS) + 1;
    endfunction

    task automatic drive_syncs(input bit rd_side, input logic vs, input logic hs,
                               input logic de);
        if (rd_side) begin
            out_vs_req = vs;
            out_hs_req = hs;
            out_de_req = de;
        end else begin
            in_vs = vs;
            in_hs = hs;
            in_de = de;
        end
    endtask

    task automatic drive_units(input bit rd_side, input int u);
        if (rd_side) begin
            out_units = repack_pkg::units_t'(u);
        end else begin
            in_units = repack_pkg::units_t'(u);
        end
    endtask

    // One frame on either side
    // Write side also feeds the scoreboard
    task automatic run_frame(input bit rd_side, input int units, input int pixels,
                             input int line_len, input int gaps);
        int                lines;
        repack_pkg::word_t pix;
        lines = pixels / line_len;
        drive_units(rd_side, units);
        drive_syncs(rd_side, 1'b1, 1'b0, 1'b0);
        repeat (SYNC_CYCLES) next_cycle();
        // Count is latched on the sync rise
        // Later changes are ignored
        drive_units(rd_side, other_units(units));
        for (int l = 0; l < lines; l++) begin
            drive_syncs(rd_side, 1'b0, 1'b1, 1'b0);
            repeat (LINE_GAP) next_cycle();
            for (int p = 0; p < line_len; p++) begin
                // Random single idle cycle inside the line
                if (gaps != 0 && p != 0 && $urandom_range(3) == 0) begin
                    drive_syncs(rd_side, 1'b0, 1'b0, 1'b0);
                    next_cycle();
                end
                if (!rd_side) begin
                    pix     = $urandom();
                    in_data = pix;
                    exp_pix_q.push_back(pix & low_unit_mask(units));
                    exp_units_q.push_back(units);
                end
                drive_syncs(rd_side, 1'b0, 1'b0, 1'b1);
                next_cycle();
            end
        end
        drive_syncs(rd_side, 1'b0, 1'b1, 1'b0);
        repeat (LINE_GAP) next_cycle();
        drive_syncs(rd_side, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic wait_write_idle();
        int idle;
        idle = 0;
        while (idle < WR_IDLE) begin
            next_cycle();
            if (dut_i.wr_en === 1'b1) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            assert (fifo_empty === 1'b1 && fifo_full === 1'b0)
            else stop_run($sformatf("ERR %0t: FIFO flags empty=%b full=%b after reset",
                                    $time, fifo_empty, fifo_full));
            assert (out_de === 1'b0 && out_vs === 1'b0)
            else stop_run($sformatf("ERR %0t: output syncs active after reset", $time));
            next_cycle();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitor at mid-cycle where inputs and outputs are settled
    //////////////////////////////////////////////////////////////////////

    always @(negedge CLK_I) begin
        if (!RST_I) begin
            assert (out_vs === vs_hist[DLY-1] && out_hs === hs_hist[DLY-1] &&
                    out_de === de_hist[DLY-1])
            else stop_run($sformatf("ERR %0t: syncs vs/hs/de=%b%b%b, expected %b%b%b",
                                    $time, out_vs, out_hs, out_de, vs_hist[DLY-1],
                                    hs_hist[DLY-1], de_hist[DLY-1]));
            if (out_de === 1'b1) begin
                assert (exp_pix_q.size() != 0)
                else stop_run($sformatf("ERR %0t: out_de with no pixel pending", $time));
                mon_exp   = exp_pix_q.pop_front();
                mon_units = exp_units_q.pop_front();
                mon_got   = out_data & low_unit_mask(mon_units);
                assert (mon_got === mon_exp)
                else stop_run($sformatf("ERR %0t: pixel %0d (%0d units) got %h expected %h",
                                        $time, rx_count, mon_units, mon_got, mon_exp));
                rx_count++;
            end
            if (dut_i.wr_en === 1'b1) begin
                total_words++;
            end
        end
        vs_hist = {vs_hist[DLY-2:0], out_vs_req};
        hs_hist = {hs_hist[DLY-2:0], out_hs_req};
        de_hist = {de_hist[DLY-2:0], out_de_req};
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run("Watchdog expired before all frames were checked");
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int words_before;
        void'($urandom(SEED));
        CLK_I      = 1'b0;
        RST_I      = 1'b1;
        in_vs      = 1'b0;
        in_hs      = 1'b0;
        in_de      = 1'b0;
        in_data    = '0;
        in_units   = '0;
        out_vs_req = 1'b0;
        out_hs_req = 1'b0;
        out_de_req = 1'b0;
        out_units  = '0;
        repeat (RESET_CYCLES) @(posedge CLK_I);
        #(DRIVE_DLY);
        RST_I = 1'b0;
        check_idle(IDLE_CHECKS);

        for (int r = 0; r < NUM_ROWS; r++) begin
            // Write the whole frame before reading it back
            words_before = total_words;
            run_frame(1'b0, ROW_UNITS[r], ROW_PIXELS[r], ROW_LINE_LEN[r], ROW_GAPS[r]);
            wait_write_idle();
            assert (total_words - words_before == ROW_WORDS[r])
            else stop_run($sformatf("ERR %0t: row %0d wrote %0d words, expected %0d",
                                    $time, r, total_words - words_before, ROW_WORDS[r]));
            // FIFO holds exactly this frame's words
            assert (fifo_empty === 1'b0 && fifo_full === (ROW_WORDS[r] == FIFO_DEPTH))
            else stop_run($sformatf("ERR %0t: row %0d FIFO empty=%b full=%b with %0d words",
                                    $time, r, fifo_empty, fifo_full, ROW_WORDS[r]));
            run_frame(1'b1, ROW_UNITS[r], ROW_PIXELS[r], ROW_LINE_LEN[r], ROW_GAPS[r]);
            // Let the output pipe drain
            repeat (DLY + 2) next_cycle();
            assert (exp_pix_q.size() == 0)
            else stop_run($sformatf("ERR %0t: row %0d left %0d pixels undelivered",
                                    $time, r, exp_pix_q.size()));
            assert (fifo_empty === 1'b1)
            else stop_run($sformatf("ERR %0t: row %0d FIFO not empty after read",
                                    $time, r));
        end

        if (fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "Checks reported errors");
        end
    end

endmodule

// File: sim.f
+incdir+common
common/repack_pkg.sv
pixel_pack/pixel_pack.sv
word_fifo/word_fifo.sv
pixel_unpack/pixel_unpack.sv
design/repack_top.sv
sim/repack_tb.sv

// File: Makefile
# Verilator build and run for the pixel repack project

VERILATOR  ?= verilator
TOP        ?= repack_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := common/repack_macros.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: run build lint clean

# Default target, the simulator's exit status is the result
run: build
	./$(BIN)

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --Mdir $(BUILD_DIR) \
		--top-module $(TOP) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
